/* build.f */
design/id_pkg.sv
design/id_dec_if.sv
design/id_stage_reg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
bench/tb_id_stage.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_id_stage
FILELIST  = build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* bench/tb_id_stage.sv */
`default_nettype none

module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS = 28;
    localparam int LIMIT = NROWS * 20 + 50;
    localparam logic [31:0] EX_D = 32'hE0E0_E0E0;
    localparam logic [31:0] MEM_D = 32'hA0A0_A0A0;
    localparam logic [31:0] WB_D = 32'hB0B0_B0B0;
    localparam logic [16:0] ADD_W = 17'h00020;
    localparam logic [16:0] SLLI_W = 17'h00081;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [2:0]  fmask;
        logic [4:0]  fa;
        logic [11:0] op;
        logic [31:0] s1;
        logic [31:0] s2;
        logic        we;
        logic [4:0]  wa;
        logic [31:0] st;
        logic [1:0]  mem;
        logic        tk;
        logic [31:0] tgt;
    } row_t;

    logic clk, resetn, if_to_id_valid, id_allowin, ex_allowin, id_to_ex_valid;
    logic [31:0] instr, pc, alu_src1, alu_src2, id_pc, st_value, br_target;
    logic [11:0] alu_op;
    logic rf_we, mem_we, res_from_mem, br_taken;
    logic [4:0] rf_waddr, ex_waddr, mem_waddr, wb_waddr;
    logic ex_we, ex_is_load, mem_we_fwd, wb_we;
    logic [31:0] ex_wdata, mem_wdata, wb_wdata;
    row_t rows [NROWS];
    int nrow = 0;
    int cycles = 0;

    id_stage id_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Some tests failed");
            $fatal(1, "run did not finish within %0d cycles", LIMIT);
        end
    end

    function automatic logic [31:0] pre(int i);
        return (i == 6) ? 32'h8000_0000 : i * 32'h0101_0101;
    endfunction

    function automatic logic [31:0] enc_3r(logic [16:0] op, int rk, int rj, int rd);
        return {op, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_i12(logic [9:0] op, logic [11:0] i12, int rj, int rd);
        return {op, i12, 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_i16(logic [5:0] op, logic [15:0] i16, int rj, int rd);
        return {op, i16, 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_i26(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic add_row(logic [31:0] i, logic [31:0] p, logic [2:0] fm, logic [4:0] fa,
                           logic [11:0] op, logic [31:0] s1, logic [31:0] s2, logic we,
                           logic [4:0] wa, logic [31:0] st, logic [1:0] mem, logic tk,
                           logic [31:0] tgt);
        rows[nrow] = '{i, p, fm, fa, op, s1, s2, we, wa, st, mem, tk, tgt};
        nrow++;
    endtask

    task automatic compare_val(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s got %h expected %h", name, got, expected);
            $display("Some tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic wait_handoff();
        int waits;
        waits = 0;
        while (!id_to_ex_valid) begin
            @(negedge clk);
            waits++;
            if (waits > 20) begin
                $display("Some tests failed");
                $fatal(1, "instruction never left the decode stage");
            end
        end
    endtask

    task automatic check_bundle(row_t r);
        compare_val("alu_op", 32'(alu_op), 32'(r.op));
        compare_val("alu_src1", alu_src1, r.s1);
        compare_val("alu_src2", alu_src2, r.s2);
        compare_val("rf_we", 32'(rf_we), 32'(r.we));
        compare_val("rf_waddr", 32'(rf_waddr), 32'(r.wa));
        compare_val("st_value", st_value, r.st);
        compare_val("mem_we", 32'(mem_we), 32'(r.mem[1]));
        compare_val("res_from_mem", 32'(res_from_mem), 32'(r.mem[0]));
        compare_val("id_pc", id_pc, r.pc);
        compare_val("br_taken", 32'(br_taken), 32'(r.tk));
        if (r.tk) begin
            compare_val("br_target", br_target, r.tgt);
        end
    endtask

    initial begin
        resetn = 1'b0;
        if_to_id_valid = 1'b0;
        instr = '0;
        pc = '0;
        ex_allowin = 1'b1;
        {ex_we, ex_is_load, mem_we_fwd, wb_we} = '0;
        {ex_waddr, mem_waddr, wb_waddr} = '0;
        ex_wdata = EX_D;
        mem_wdata = MEM_D;
        wb_wdata = '0;

        // alu and memory decode
        add_row(enc_3r(ADD_W, 3, 2, 7), 32'h1000, 0, 0, 12'h001, pre(2), pre(3), 1, 7,
                pre(3), 0, 0, 0);
        add_row(enc_i12(10'h00a, 12'hffc, 2, 8), 32'h1004, 0, 0, 12'h001, pre(2),
                32'hffff_fffc, 1, 8, pre(28), 0, 0, 0);
        add_row(enc_i12(10'h00d, 12'h8f0, 3, 9), 32'h1008, 0, 0, 12'h010, pre(3),
                32'h0000_08f0, 1, 9, pre(16), 0, 0, 0);
        add_row(enc_3r(SLLI_W, 4, 2, 10), 32'h100c, 0, 0, 12'h100, pre(2), 32'h24, 1, 10,
                pre(4), 0, 0, 0);
        add_row({id_pkg::OP6_LU12I, 1'b0, 20'h12345, 5'd11}, 32'h1010, 0, 0, 12'h800,
                pre(5), 32'h1234_5000, 1, 11, pre(26), 0, 0, 0);
        add_row({id_pkg::OP6_PCADDU12I, 1'b0, 20'h00001, 5'd12}, 32'h2000, 0, 0, 12'h001,
                32'h2000, 32'h1000, 1, 12, 0, 0, 0, 0);
        add_row(enc_i12({id_pkg::OP6_MEM, 4'h2}, 12'h008, 2, 13), 32'h1018, 0, 0, 12'h001,
                pre(2), 32'h8, 1, 13, pre(8), 2'b01, 0, 0);
        add_row(enc_i12({id_pkg::OP6_MEM, 4'h6}, 12'h00c, 2, 4), 32'h101c, 0, 0, 12'h001,
                pre(2), 32'hc, 0, 4, pre(4), 2'b10, 0, 0);
        // forwarding priority ex over mem over wb and r0 never forwarded
        add_row(enc_3r(ADD_W, 0, 20, 7), 32'h1020, 3'b111, 20, 12'h001, EX_D, 0, 1, 7, 0, 0, 0, 0);
        add_row(enc_3r(ADD_W, 0, 21, 7), 32'h1024, 3'b011, 21, 12'h001, MEM_D, 0, 1, 7, 0, 0, 0, 0);
        add_row(enc_3r(ADD_W, 0, 22, 7), 32'h1028, 3'b001, 22, 12'h001, WB_D, 0, 1, 7, 0, 0, 0, 0);
        add_row(enc_3r(ADD_W, 0, 0, 7), 32'h102c, 3'b111, 0, 12'h001, 0, 0, 1, 7, 0, 0, 0, 0);
        // conditional branches taken and not taken with target pc + 16
        add_row(enc_i16(id_pkg::OP6_BEQ, 4, 2, 2), 32'h3000, 0, 0, 0, pre(2), pre(2), 0, 2,
                pre(2), 0, 1, 32'h3010);
        add_row(enc_i16(id_pkg::OP6_BEQ, 4, 2, 3), 32'h3000, 0, 0, 0, pre(2), pre(3), 0, 3,
                pre(3), 0, 0, 0);
        add_row(enc_i16(id_pkg::OP6_BNE, 4, 2, 3), 32'h3000, 0, 0, 0, pre(2), pre(3), 0, 3,
                pre(3), 0, 1, 32'h3010);
        add_row(enc_i16(id_pkg::OP6_BNE, 4, 2, 2), 32'h3000, 0, 0, 0, pre(2), pre(2), 0, 2,
                pre(2), 0, 0, 0);
        add_row(enc_i16(id_pkg::OP6_BLT, 4, 6, 2), 32'h3000, 0, 0, 0, pre(6), pre(2), 0, 2,
                pre(2), 0, 1, 32'h3010);
        add_row(enc_i16(id_pkg::OP6_BLT, 4, 2, 6), 32'h3000, 0, 0, 0, pre(2), pre(6), 0, 6,
                pre(6), 0, 0, 0);
        add_row(enc_i16(id_pkg::OP6_BGE, 4, 2, 6), 32'h3000, 0, 0, 0, pre(2), pre(6), 0, 6,
                pre(6), 0, 1, 32'h3010);
        add_row(enc_i16(id_pkg::OP6_BGE, 4, 6, 2), 32'h3000, 0, 0, 0, pre(6), pre(2), 0, 2,
                pre(2), 0, 0, 0);
        add_row(enc_i16(id_pkg::OP6_BLTU, 4, 2, 6), 32'h3000, 0, 0, 0, pre(2), pre(6), 0, 6,
                pre(6), 0, 1, 32'h3010);
        add_row(enc_i16(id_pkg::OP6_BLTU, 4, 6, 2), 32'h3000, 0, 0, 0, pre(6), pre(2), 0, 2,
                pre(2), 0, 0, 0);
        add_row(enc_i16(id_pkg::OP6_BGEU, 4, 6, 2), 32'h3000, 0, 0, 0, pre(6), pre(2), 0, 2,
                pre(2), 0, 1, 32'h3010);
        add_row(enc_i16(id_pkg::OP6_BGEU, 4, 2, 6), 32'h3000, 0, 0, 0, pre(2), pre(6), 0, 6,
                pre(6), 0, 0, 0);
        // b, bl, jirl, then an unknown opcode
        add_row(enc_i26(id_pkg::OP6_B, 26'h100), 32'h3000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1,
                32'h3400);
        add_row(enc_i26(id_pkg::OP6_BL, 26'h3ff_ffff), 32'h3000, 0, 0, 12'h001, 32'h3000, 4,
                1, 1, pre(31), 0, 1, 32'h2ffc);
        add_row(enc_i16(id_pkg::OP6_JIRL, 16'h10, 2, 7), 32'h3000, 0, 0, 12'h001, 32'h3000, 4,
                1, 7, pre(16), 0, 1, 32'h0202_0242);
        add_row(32'hfc00_0000, 32'h5000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);

        repeat (10) @(negedge clk);
        resetn = 1'b1;
        compare_val("id_allowin", 32'(id_allowin), 1);
        compare_val("id_to_ex_valid", 32'(id_to_ex_valid), 0);

        // preload r1..r31 through the wb port
        for (int i = 1; i < 32; i++) begin
            wb_we = 1'b1;
            wb_waddr = 5'(i);
            wb_wdata = pre(i);
            @(negedge clk);
        end
        wb_we = 1'b0;

        foreach (rows[i]) begin
            instr = rows[i].instr;
            pc = rows[i].pc;
            if_to_id_valid = 1'b1;
            {ex_we, mem_we_fwd, wb_we} = '0;
            @(posedge clk);
            @(negedge clk);
            if_to_id_valid = 1'b0;
            wait_handoff();
            // forwarding shows up after capture so the regfile still holds the preload
            {ex_we, mem_we_fwd, wb_we} = rows[i].fmask;
            {ex_waddr, mem_waddr, wb_waddr} = {3{rows[i].fa}};
            wb_wdata = WB_D;
            if (rows[i].tk) begin
                // wrong-path fetch presented on the hand-off edge
                if_to_id_valid = 1'b1;
                instr = '0;
            end
            #1;
            check_bundle(rows[i]);
            @(negedge clk);
            if (rows[i].tk) begin
                if_to_id_valid = 1'b0;
                compare_val("id_to_ex_valid", 32'(id_to_ex_valid), 0);
            end
        end
        {ex_we, mem_we_fwd, wb_we} = '0;

        // load-use stall on rj
        instr = enc_3r(ADD_W, 0, 2, 7);
        pc = 32'h6000;
        if_to_id_valid = 1'b1;
        {ex_we, ex_is_load, ex_waddr} = {2'b11, 5'd2};
        @(negedge clk);
        if_to_id_valid = 1'b0;
        repeat (3) begin
            compare_val("id_to_ex_valid", 32'(id_to_ex_valid), 0);
            compare_val("id_allowin", 32'(id_allowin), 0);
            @(negedge clk);
        end
        {ex_we, ex_is_load} = '0;
        {mem_we_fwd, mem_waddr} = {1'b1, 5'd2};
        #2;
        compare_val("id_to_ex_valid", 32'(id_to_ex_valid), 1);
        compare_val("alu_src1", alu_src1, MEM_D);
        @(negedge clk);
        mem_we_fwd = 1'b0;

        // back-pressure on a taken bne
        instr = enc_i16(id_pkg::OP6_BNE, 4, 2, 3);
        pc = 32'h4000;
        if_to_id_valid = 1'b1;
        ex_allowin = 1'b0;
        @(negedge clk);
        if_to_id_valid = 1'b0;
        repeat (4) begin
            compare_val("id_allowin", 32'(id_allowin), 0);
            compare_val("id_to_ex_valid", 32'(id_to_ex_valid), 1);
            compare_val("br_taken", 32'(br_taken), 0);
            compare_val("alu_src1", alu_src1, pre(2));
            compare_val("br_target", br_target, 32'h4010);
            @(negedge clk);
        end
        ex_allowin = 1'b1;
        #2;
        compare_val("br_taken", 32'(br_taken), 1);
        @(negedge clk);
        compare_val("id_to_ex_valid", 32'(id_to_ex_valid), 0);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/id_stage.sv */
`default_nettype none

module id_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              if_to_id_valid,
    input  id_pkg::word_t     instr,
    input  id_pkg::word_t     pc,
    output logic              id_allowin,
    input  logic              ex_allowin,
    output logic              id_to_ex_valid,
    output id_pkg::alu_op_t   alu_op,
    output id_pkg::word_t     alu_src1,
    output id_pkg::word_t     alu_src2,
    output logic              rf_we,
    output id_pkg::reg_addr_t rf_waddr,
    output id_pkg::word_t     id_pc,
    output id_pkg::word_t     st_value,
    output logic              mem_we,
    output logic              res_from_mem,
    output logic              br_taken,
    output id_pkg::word_t     br_target,
    input  logic              ex_we,
    input  id_pkg::reg_addr_t ex_waddr,
    input  id_pkg::word_t     ex_wdata,
    input  logic              ex_is_load,
    input  logic              mem_we_fwd,
    input  id_pkg::reg_addr_t mem_waddr,
    input  id_pkg::word_t     mem_wdata,
    input  logic              wb_we,
    input  id_pkg::reg_addr_t wb_waddr,
    input  id_pkg::word_t     wb_wdata
);

    logic          id_valid;
    logic          stall;
    id_pkg::word_t id_instr;
    id_pkg::word_t rj_value;

    id_dec_if dec_bus ();

    assign id_to_ex_valid = id_valid & ~stall;

    id_stage_reg u_stage_reg (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (if_to_id_valid),
        .in_instr   (instr),
        .in_pc      (pc),
        .stall      (stall),
        .ex_allowin (ex_allowin),
        .br_taken   (br_taken),
        .allowin    (id_allowin),
        .id_valid   (id_valid),
        .instr      (id_instr),
        .pc         (id_pc)
    );

    inst_decoder u_decoder (
        .instr        (id_instr),
        .dec          (dec_bus.dec),
        .alu_op       (alu_op),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .mem_we       (mem_we),
        .res_from_mem (res_from_mem)
    );

    operand_bypass u_bypass (
        .clk        (clk),
        .dec        (dec_bus.opnd),
        .pc         (id_pc),
        .id_valid   (id_valid),
        .ex_we      (ex_we),
        .ex_waddr   (ex_waddr),
        .ex_wdata   (ex_wdata),
        .ex_is_load (ex_is_load),
        .mem_we_fwd (mem_we_fwd),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .wb_we      (wb_we),
        .wb_waddr   (wb_waddr),
        .wb_wdata   (wb_wdata),
        .rj_value   (rj_value),
        .rkd_value  (st_value),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .stall      (stall)
    );

    branch_unit u_branch (
        .dec       (dec_bus.br),
        .pc        (id_pc),
        .rj_value  (rj_value),
        .rkd_value (st_value),
        .fire      (id_to_ex_valid & ex_allowin),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`default_nettype none

module branch_unit (
    id_dec_if.br          dec,
    input  id_pkg::word_t pc,
    input  id_pkg::word_t rj_value,
    input  id_pkg::word_t rkd_value,
    input  logic          fire,
    output logic          br_taken,
    output id_pkg::word_t br_target
);

    logic cond;

    wire eq   = (rj_value == rkd_value);
    wire lt_s = ($signed(rj_value) < $signed(rkd_value));
    wire lt_u = (rj_value < rkd_value);

    always_comb begin
        case (dec.br_kind)
            id_pkg::BR_EQ:     cond = eq;
            id_pkg::BR_NE:     cond = ~eq;
            id_pkg::BR_LT:     cond = lt_s;
            id_pkg::BR_GE:     cond = ~lt_s;
            id_pkg::BR_LTU:    cond = lt_u;
            id_pkg::BR_GEU:    cond = ~lt_u;
            id_pkg::BR_ALWAYS: cond = 1'b1;
            default:           cond = 1'b0;
        endcase
    end

    // only redirect fetch on the hand-off cycle
    assign br_taken  = fire & cond;
    assign br_target = (dec.br_uses_rj ? rj_value : pc) + dec.br_offs;

endmodule

`default_nettype wire

/* design/operand_bypass.sv */
`default_nettype none

module operand_bypass (
    input  logic              clk,
    id_dec_if.opnd            dec,
    input  id_pkg::word_t     pc,
    input  logic              id_valid,
    input  logic              ex_we,
    input  id_pkg::reg_addr_t ex_waddr,
    input  id_pkg::word_t     ex_wdata,
    input  logic              ex_is_load,
    input  logic              mem_we_fwd,
    input  id_pkg::reg_addr_t mem_waddr,
    input  id_pkg::word_t     mem_wdata,
    input  logic              wb_we,
    input  id_pkg::reg_addr_t wb_waddr,
    input  id_pkg::word_t     wb_wdata,
    output id_pkg::word_t     rj_value,
    output id_pkg::word_t     rkd_value,
    output id_pkg::word_t     alu_src1,
    output id_pkg::word_t     alu_src2,
    output logic              stall
);

    id_pkg::word_t rf_rdata1;
    id_pkg::word_t rf_rdata2;

    function automatic logic hit(id_pkg::reg_addr_t ra, logic we, id_pkg::reg_addr_t wa);
        return (ra != '0) && we && (ra == wa);
    endfunction

    // youngest producer wins
    function automatic id_pkg::word_t fwd(id_pkg::reg_addr_t ra, id_pkg::word_t rf_data);
        if (hit(ra, ex_we, ex_waddr)) begin
            return ex_wdata;
        end else if (hit(ra, mem_we_fwd, mem_waddr)) begin
            return mem_wdata;
        end else if (hit(ra, wb_we, wb_waddr)) begin
            return wb_wdata;
        end
        return rf_data;
    endfunction

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (dec.raddr2),
        .rdata2 (rf_rdata2),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata)
    );

    always_comb begin
        rj_value  = fwd(dec.raddr1, rf_rdata1);
        rkd_value = fwd(dec.raddr2, rf_rdata2);
    end

    // load data only ready in mem
    assign stall = id_valid & ex_is_load &
                   ((dec.need_r1 & hit(dec.raddr1, ex_we, ex_waddr)) |
                    (dec.need_r2 & hit(dec.raddr2, ex_we, ex_waddr)));

    assign alu_src1 = dec.src1_is_pc  ? pc      : rj_value;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rkd_value;

endmodule

`default_nettype wire

/* design/regfile.sv */
`default_nettype none

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    input  logic              we,
    input  id_pkg::reg_addr_t waddr,
    input  id_pkg::word_t     wdata
);

    id_pkg::word_t rf [id_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
`default_nettype none

module inst_decoder (
    input  id_pkg::word_t     instr,
    id_dec_if.dec             dec,
    output id_pkg::alu_op_t   alu_op,
    output logic              rf_we,
    output id_pkg::reg_addr_t rf_waddr,
    output logic              mem_we,
    output logic              res_from_mem
);

    wire [5:0]  op6 = instr[31:26];
    wire [3:0]  op4 = instr[25:22];
    wire [1:0]  op2 = instr[21:20];
    wire [4:0]  op5 = instr[19:15];
    wire [4:0]  rd  = instr[4:0];
    wire [4:0]  rj  = instr[9:5];
    wire [4:0]  rk  = instr[14:10];
    wire [11:0] i12 = instr[21:10];
    wire [19:0] i20 = instr[24:5];
    wire [15:0] i16 = instr[25:10];
    wire [25:0] i26 = {instr[9:0], instr[25:10]};

    wire op_alu = (op6 == id_pkg::OP6_ALU);
    // three-register group
    wire rr_grp = op_alu & (op4 == 4'h0) & (op2 == 2'h1);
    wire sh_grp = op_alu & (op4 == 4'h1) & (op2 == 2'h0);

    wire inst_add_w  = rr_grp & (op5 == 5'h00);
    wire inst_sub_w  = rr_grp & (op5 == 5'h02);
    wire inst_slt    = rr_grp & (op5 == 5'h04);
    wire inst_sltu   = rr_grp & (op5 == 5'h05);
    wire inst_nor    = rr_grp & (op5 == 5'h08);
    wire inst_and    = rr_grp & (op5 == 5'h09);
    wire inst_or     = rr_grp & (op5 == 5'h0a);
    wire inst_xor    = rr_grp & (op5 == 5'h0b);
    wire inst_sll_w  = rr_grp & (op5 == 5'h0e);
    wire inst_srl_w  = rr_grp & (op5 == 5'h0f);
    wire inst_sra_w  = rr_grp & (op5 == 5'h10);
    wire inst_slli_w = sh_grp & (op5 == 5'h01);
    wire inst_srli_w = sh_grp & (op5 == 5'h09);
    wire inst_srai_w = sh_grp & (op5 == 5'h11);
    wire inst_slti   = op_alu & (op4 == 4'h8);
    wire inst_sltui  = op_alu & (op4 == 4'h9);
    wire inst_addi_w = op_alu & (op4 == 4'ha);
    wire inst_andi   = op_alu & (op4 == 4'hd);
    wire inst_ori    = op_alu & (op4 == 4'he);
    wire inst_xori   = op_alu & (op4 == 4'hf);
    wire inst_ld_w   = (op6 == id_pkg::OP6_MEM) & (op4 == 4'h2);
    wire inst_st_w   = (op6 == id_pkg::OP6_MEM) & (op4 == 4'h6);
    wire inst_lu12i  = (op6 == id_pkg::OP6_LU12I) & ~instr[25];
    wire inst_pcadd  = (op6 == id_pkg::OP6_PCADDU12I) & ~instr[25];
    wire inst_jirl   = (op6 == id_pkg::OP6_JIRL);
    wire inst_b      = (op6 == id_pkg::OP6_B);
    wire inst_bl     = (op6 == id_pkg::OP6_BL);

    wire rr_op   = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and |
                   inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    wire shi_op  = inst_slli_w | inst_srli_w | inst_srai_w;
    wire si12_op = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    wire ui12_op = inst_andi | inst_ori | inst_xori;
    wire u20_op  = inst_lu12i | inst_pcadd;
    wire link_op = inst_jirl | inst_bl;
    wire cond_br = (dec.br_kind != id_pkg::BR_NONE) & (dec.br_kind != id_pkg::BR_ALWAYS);

    assign alu_op[id_pkg::ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w |
                                      link_op | inst_pcadd;
    assign alu_op[id_pkg::ALU_SUB]  = inst_sub_w;
    assign alu_op[id_pkg::ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[id_pkg::ALU_SLTU] = inst_sltu | inst_sltui;
    assign alu_op[id_pkg::ALU_AND]  = inst_and | inst_andi;
    assign alu_op[id_pkg::ALU_NOR]  = inst_nor;
    assign alu_op[id_pkg::ALU_OR]   = inst_or | inst_ori;
    assign alu_op[id_pkg::ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[id_pkg::ALU_SLL]  = inst_sll_w | inst_slli_w;
    assign alu_op[id_pkg::ALU_SRL]  = inst_srl_w | inst_srli_w;
    assign alu_op[id_pkg::ALU_SRA]  = inst_sra_w | inst_srai_w;
    assign alu_op[id_pkg::ALU_LUI]  = inst_lu12i;

    // ui5 shares the sign-extended i12 path
    assign dec.imm = link_op            ? id_pkg::LINK_OFFSET :
                     u20_op             ? {i20, 12'b0} :
                     (shi_op | si12_op) ? {{20{i12[11]}}, i12} :
                                          {20'b0, i12};
    assign dec.br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                              {{14{i16[15]}}, i16, 2'b0};

    always_comb begin
        case (op6)
            id_pkg::OP6_BEQ:  dec.br_kind = id_pkg::BR_EQ;
            id_pkg::OP6_BNE:  dec.br_kind = id_pkg::BR_NE;
            id_pkg::OP6_BLT:  dec.br_kind = id_pkg::BR_LT;
            id_pkg::OP6_BGE:  dec.br_kind = id_pkg::BR_GE;
            id_pkg::OP6_BLTU: dec.br_kind = id_pkg::BR_LTU;
            id_pkg::OP6_BGEU: dec.br_kind = id_pkg::BR_GEU;
            id_pkg::OP6_B, id_pkg::OP6_BL, id_pkg::OP6_JIRL:
                dec.br_kind = id_pkg::BR_ALWAYS;
            default:          dec.br_kind = id_pkg::BR_NONE;
        endcase
    end

    assign dec.br_uses_rj  = inst_jirl;
    assign dec.raddr1      = rj;
    assign dec.raddr2      = (cond_br | inst_st_w) ? rd : rk;
    assign dec.need_r1     = rr_op | shi_op | si12_op | ui12_op | cond_br | inst_jirl;
    assign dec.need_r2     = rr_op | inst_st_w | cond_br;
    assign dec.src1_is_pc  = link_op | inst_pcadd;
    assign dec.src2_is_imm = shi_op | si12_op | ui12_op | u20_op | link_op;

    // stores, conditional branches, b and unknown opcodes stay silent
    assign rf_we        = rr_op | shi_op | ui12_op | u20_op | link_op | (si12_op & ~inst_st_w);
    assign rf_waddr     = inst_bl ? id_pkg::RA_REG : rd;
    assign mem_we       = inst_st_w;
    assign res_from_mem = inst_ld_w;

    always_comb begin
        if (!$isunknown(instr)) begin
            assert final ($onehot0(alu_op));
        end
    end

endmodule

`default_nettype wire

/* design/id_stage_reg.sv */
`default_nettype none

module id_stage_reg (
    input  logic          clk,
    input  logic          resetn,
    input  logic          in_valid,
    input  id_pkg::word_t in_instr,
    input  id_pkg::word_t in_pc,
    input  logic          stall,
    input  logic          ex_allowin,
    input  logic          br_taken,
    output logic          allowin,
    output logic          id_valid,
    output id_pkg::word_t instr,
    output id_pkg::word_t pc
);

    assign allowin = ~id_valid | (~stall & ex_allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            // instruction behind a taken branch is on the wrong path
            id_valid <= 1'b0;
        end else if (allowin) begin
            id_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            instr <= in_instr;
            pc    <= in_pc;
        end
    end

    held_while_blocked: assert property (
        @(posedge clk) disable iff (!resetn)
        id_valid && !ex_allowin |=> id_valid && $stable(instr) && $stable(pc)
    );

endmodule

`default_nettype wire

/* design/id_dec_if.sv */
`default_nettype none

interface id_dec_if;

    id_pkg::reg_addr_t raddr1;
    id_pkg::reg_addr_t raddr2;
    logic              need_r1;
    logic              need_r2;
    logic              src1_is_pc;
    logic              src2_is_imm;
    id_pkg::word_t     imm;
    id_pkg::br_kind_t  br_kind;
    id_pkg::word_t     br_offs;
    // jirl targets rj + offset
    logic              br_uses_rj;

    modport dec (
        output raddr1, raddr2, need_r1, need_r2, src1_is_pc, src2_is_imm, imm,
        output br_kind, br_offs, br_uses_rj
    );

    modport opnd (
        input raddr1, raddr2, need_r1, need_r2, src1_is_pc, src2_is_imm, imm
    );

    modport br (
        input br_kind, br_offs, br_uses_rj
    );

endinterface

`default_nettype wire

/* design/id_pkg.sv */
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;
    typedef logic [2:0]  br_kind_t;

    // one-hot bit positions in alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam int        NUM_REGS    = 32;
    localparam reg_addr_t RA_REG      = 5'd1;
    localparam word_t     LINK_OFFSET = 32'd4;

    // major opcode, instr[31:26]
    localparam logic [5:0] OP6_ALU       = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    localparam br_kind_t BR_NONE   = 3'd0;
    localparam br_kind_t BR_EQ     = 3'd1;
    localparam br_kind_t BR_NE     = 3'd2;
    localparam br_kind_t BR_LT     = 3'd3;
    localparam br_kind_t BR_GE     = 3'd4;
    localparam br_kind_t BR_LTU    = 3'd5;
    localparam br_kind_t BR_GEU    = 3'd6;
    localparam br_kind_t BR_ALWAYS = 3'd7;

endpackage

`default_nettype wire
